//--- bench/adc_cap_tb.sv
`timescale 1ns/1ps

module adc_cap_tb;
    import adc_cap_pkg::*;

    typedef struct packed {
        logic [1:0]  chsel;
        logic [31:0] num;
        logic [15:0] div;
        logic        stream;
        logic [7:0]  prob;       // credit return chance in percent
        logic        bad_first;  // broken frame ahead of the settings
        logic [31:0] exp_words;
    } row_t;

    localparam int NUM_ROWS    = 8;
    localparam int DRAIN_QUIET = 24;  // idle cycles that mean the chain is empty

    logic        clk50m           = 1'b0;
    logic        rst_i            = 1'b1;
    logic [7:0]  cmd_byte_i       = 8'h00;
    logic        cmd_byte_valid_i = 1'b0;
    logic [11:0] adc_data_i       = 12'h000;
    logic        adc_mux_o;
    logic        credit_i         = 1'b0;
    tx_word_t    tx_o;
    logic        tx_valid_o;
    logic        busy_o;
    logic        overflow_o;

    row_t        rows [NUM_ROWS];
    tx_word_t    rx_q [$];
    int          words_rx      = 0;
    int          credits_ret   = 0;
    int          cur_prob      = 100;
    logic        draining      = 1'b0;
    logic [31:0] lcg_state     = 32'h67bb_f5e8;
    int          cycle_cnt     = 0;
    int          timeout_limit = 1000000;

    adc_cap_top u_adc_cap_top (
        .clk50m(clk50m), .rst_i(rst_i), .cmd_byte_i(cmd_byte_i),
        .cmd_byte_valid_i(cmd_byte_valid_i), .adc_data_i(adc_data_i),
        .adc_mux_o(adc_mux_o), .credit_i(credit_i), .tx_o(tx_o),
        .tx_valid_o(tx_valid_o), .busy_o(busy_o), .overflow_o(overflow_o)
    );

    always #10 clk50m = ~clk50m;

    // free-running ADC model, value is the cycle count
    always @(negedge clk50m) adc_data_i = adc_data_i + 12'd1;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    // sink takes every word and hands credits back at random
    always @(negedge clk50m) begin
        if (rst_i) begin
            credit_i = 1'b0;
        end else begin
            if (tx_valid_o) begin
                rx_q.push_back(tx_o);
                words_rx = words_rx + 1;
            end
            if (words_rx - credits_ret > TX_CREDITS) begin
                $display("sink holds %0d unpaid words, more than the credit limit allows",
                         words_rx - credits_ret);
                stop_run();
            end
            lcg_state = lcg_next(lcg_state);
            if (words_rx > credits_ret && (draining || lcg_state[31:16] % 100 < cur_prob)) begin
                credit_i    = 1'b1;
                credits_ret = credits_ret + 1;
            end else begin
                credit_i = 1'b0;
            end
        end
    end

    always @(posedge clk50m) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > timeout_limit) begin
            $display("timeout: DUT did not finish within %0d cycles", timeout_limit);
            stop_run();
        end
    end

    task automatic send_byte(input logic [7:0] b);
        @(negedge clk50m);
        cmd_byte_i       = b;
        cmd_byte_valid_i = 1'b1;
    endtask

    task automatic send_frame(input logic [7:0] addr, input logic [31:0] data,
                              input logic [7:0] trailer);
        send_byte(CMD_HDR0);
        send_byte(CMD_HDR1);
        send_byte(addr);
        send_byte(data[31:24]);  // msb first
        send_byte(data[23:16]);
        send_byte(data[15:8]);
        send_byte(data[7:0]);
        send_byte(trailer);
        @(negedge clk50m);
        cmd_byte_valid_i = 1'b0;
    endtask

    task automatic load_table();
        rows[0] = '{2'b01, 32'd16,  16'd3, 1'b0, 8'd100, 1'b0, 32'd16};  // channel A
        rows[1] = '{2'b10, 32'd12,  16'd2, 1'b0, 8'd100, 1'b0, 32'd12};  // channel B
        rows[2] = '{2'b11, 32'd10,  16'd1, 1'b0, 8'd100, 1'b0, 32'd20};  // A and B
        rows[3] = '{2'b01, 32'd40,  16'd1, 1'b0, 8'd15,  1'b0, 32'd40};  // sparse credits
        rows[4] = '{2'b01, 32'd40,  16'd2, 1'b0, 8'd100, 1'b1, 32'd40};  // num kept from row 3
        rows[5] = '{2'b11, 32'd5,   16'd3, 1'b1, 8'd100, 1'b0, 32'd24};  // stream
        rows[6] = '{2'b01, 32'd100, 16'd0, 1'b0, 8'd0,   1'b0, 32'd4};   // stalled sink
        rows[7] = '{2'b10, 32'd9,   16'd0, 1'b0, 8'd50,  1'b0, 32'd9};
    endtask

    task automatic run_row(input row_t row);
        logic [31:0] target;
        tx_word_t    w;
        logic [11:0] prev_val;
        logic        exp_chan;
        logic        exp_last;
        logic        strict;
        int          idx;
        int          quiet;

        target   = (row.chsel == 2'b11) ? row.num * 2 : row.num;
        strict   = !row.stream && row.prob != 0;
        cur_prob = row.prob;
        prev_val = '0;
        if (row.bad_first) begin
            send_byte(CMD_HDR0);  // stray start, parser has to resync
            send_byte(8'h00);
            send_frame(ADDR_NUM, 32'd5, ~CMD_TRAILER);
        end else begin
            send_frame(ADDR_NUM, row.num, CMD_TRAILER);
        end
        send_frame(ADDR_CHSEL, 32'(row.chsel), CMD_TRAILER);
        send_frame(ADDR_DIV, 32'(row.div), CMD_TRAILER);
        send_frame(ADDR_STREAM, 32'(row.stream), CMD_TRAILER);
        send_frame(ADDR_RESTART, 32'd0, CMD_TRAILER);

        while (!busy_o) @(negedge clk50m);
        check_eq("overflow_o", overflow_o, 0);  // restart clears it
        check_eq("adc_mux_o", adc_mux_o, row.chsel == 2'b10);  // starts on B only for 10

        for (idx = 0; idx < row.exp_words; idx++) begin
            while (rx_q.size() == 0) @(posedge clk50m);
            w        = rx_q.pop_front();
            exp_chan = (row.chsel == 2'b11) ? idx[0] : (row.chsel == 2'b10);
            exp_last = ((idx + 1) % PKT_WORDS == 0) || (!row.stream && idx == target - 1);
            check_eq("tx_o.data.chan", w.data.chan, exp_chan);
            check_eq("tx_o.data.pad", w.data.pad, 0);
            check_eq("tx_o.last", w.last, exp_last);
            if (idx > 0)
                check_eq("tx_o.data.value", w.data.value, 12'(prev_val + row.div[11:0] + 12'd1));
            prev_val = w.data.value;
        end

        if (row.stream) send_frame(ADDR_STREAM, 32'd0, CMD_TRAILER);
        @(negedge clk50m);
        if (strict) check_eq("busy_o", busy_o, 0);
        while (busy_o) @(negedge clk50m);
        check_eq("overflow_o", overflow_o, row.prob == 0);

        // empty the buffer with every credit handed straight back
        draining = 1'b1;
        quiet    = 0;
        while (quiet < DRAIN_QUIET) begin
            @(negedge clk50m);
            quiet = tx_valid_o ? 0 : quiet + 1;
        end
        draining = 1'b0;
        if (strict) check_eq("rx word count", row.exp_words + rx_q.size(), row.exp_words);
        rx_q.delete();
    endtask

    initial begin
        int r;
        int span;

        load_table();
        timeout_limit = 2000;
        for (r = 0; r < NUM_ROWS; r++) begin
            span = (rows[r].num > rows[r].exp_words) ? rows[r].num : rows[r].exp_words;
            timeout_limit = timeout_limit + span * (rows[r].div + 1) * 4 + 600;
        end

        repeat (4) @(posedge clk50m);
        @(negedge clk50m);
        rst_i = 1'b0;
        check_eq("tx_valid_o", tx_valid_o, 0);
        check_eq("busy_o", busy_o, 0);
        check_eq("overflow_o", overflow_o, 0);
        repeat (40) begin  // idle without a restart
            @(negedge clk50m);
            check_eq("tx_valid_o", tx_valid_o, 0);
            check_eq("busy_o", busy_o, 0);
            check_eq("adc_mux_o", adc_mux_o, 0);  // default is channel A
        end

        for (r = 0; r < NUM_ROWS; r++) run_row(rows[r]);

        $display("all tests passed");
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the ADC capture testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f sim.f --top-module adc_cap_tb -o Vadc_cap_tb

./obj_dir/Vadc_cap_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

//--- sim.f
src/adc_cap_pkg.sv
src/cmd_parser.sv
src/cfg_regs.sv
src/sample_front.sv
src/sample_buffer.sv
src/capture_ctrl.sv
src/pkt_sender.sv
src/adc_cap_top.sv
bench/adc_cap_tb.sv

//--- src/adc_cap_pkg.sv
package adc_cap_pkg;

    // command frame markers
    localparam logic [7:0] CMD_HDR0    = 8'h55;
    localparam logic [7:0] CMD_HDR1    = 8'hA5;
    localparam logic [7:0] CMD_TRAILER = 8'hF0;
    localparam int         CMD_BODY_LEN = 5;     // address byte plus four data bytes

    // register map
    localparam logic [7:0] ADDR_CHSEL   = 8'h01;
    localparam logic [7:0] ADDR_NUM     = 8'h02;
    localparam logic [7:0] ADDR_DIV     = 8'h03;
    localparam logic [7:0] ADDR_RESTART = 8'h04;
    localparam logic [7:0] ADDR_STREAM  = 8'h05;

    localparam logic [1:0]  DEF_CHSEL = 2'b01;   // channel A only
    localparam logic [31:0] DEF_NUM   = 32'd16;
    localparam logic [15:0] DEF_DIV   = 16'd3;

    localparam int BUF_DEPTH  = 64;
    localparam int PKT_WORDS  = 8;
    localparam int PKT_CNT_W  = $clog2(PKT_WORDS);
    localparam int TX_CREDITS = 4;
    localparam int CRED_W     = $clog2(TX_CREDITS + 1);

    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] data;
    } cmd_t;

    typedef struct packed {
        logic [1:0]  chsel;
        logic [31:0] num;
        logic [15:0] div;
        logic        stream;
    } cfg_t;

    typedef struct packed {
        logic        chan;  // 0 = A, 1 = B
        logic [2:0]  pad;
        logic [11:0] value;
    } sample_t;

    typedef struct packed {
        logic    last;
        sample_t data;
    } tx_word_t;

endpackage

//--- src/adc_cap_top.sv
`timescale 1ns/1ps

module adc_cap_top (
    input  logic                   clk50m,
    input  logic                   rst_i,
    input  logic [7:0]             cmd_byte_i,
    input  logic                   cmd_byte_valid_i,
    input  logic [11:0]            adc_data_i,
    output logic                   adc_mux_o,
    input  logic                   credit_i,
    output adc_cap_pkg::tx_word_t  tx_o,
    output logic                   tx_valid_o,
    output logic                   busy_o,
    output logic                   overflow_o
);
    import adc_cap_pkg::*;

    cmd_t     cmd;
    logic     cmd_valid;
    cfg_t     cfg;
    logic     restart;
    logic     sample_en;
    sample_t  sample;
    logic     sample_valid;
    logic     wr_en;
    tx_word_t wr_data;
    logic     buf_full;
    logic     buf_empty;
    logic     buf_rd;
    tx_word_t buf_data;

    cmd_parser u_cmd_parser (
        .clk50m(clk50m), .rst_i(rst_i), .cmd_byte_i(cmd_byte_i),
        .cmd_byte_valid_i(cmd_byte_valid_i), .cmd_o(cmd), .cmd_valid_o(cmd_valid)
    );

    cfg_regs u_cfg_regs (
        .clk50m(clk50m), .rst_i(rst_i), .cmd_i(cmd), .cmd_valid_i(cmd_valid),
        .cfg_o(cfg), .restart_o(restart)
    );

    sample_front u_sample_front (
        .clk50m(clk50m), .rst_i(rst_i), .cfg_i(cfg), .sample_en_i(sample_en),
        .adc_data_i(adc_data_i), .adc_mux_o(adc_mux_o), .sample_o(sample),
        .sample_valid_o(sample_valid)
    );

    capture_ctrl u_capture_ctrl (
        .clk50m(clk50m), .rst_i(rst_i), .cfg_i(cfg), .restart_i(restart),
        .sample_i(sample), .sample_valid_i(sample_valid), .buf_full_i(buf_full),
        .sample_en_o(sample_en), .busy_o(busy_o), .overflow_o(overflow_o),
        .wr_en_o(wr_en), .wr_data_o(wr_data)
    );

    // on-chip stand-in for the DDR3 frame store
    sample_buffer #(.DEPTH(BUF_DEPTH)) u_sample_buffer (
        .clk50m(clk50m), .rst_i(rst_i), .wr_en_i(wr_en), .wr_data_i(wr_data),
        .rd_en_i(buf_rd), .rd_data_o(buf_data), .full_o(buf_full), .empty_o(buf_empty)
    );

    pkt_sender u_pkt_sender (
        .clk50m(clk50m), .rst_i(rst_i), .buf_empty_i(buf_empty), .buf_data_i(buf_data),
        .buf_rd_o(buf_rd), .credit_i(credit_i), .tx_o(tx_o), .tx_valid_o(tx_valid_o)
    );

endmodule

//--- src/capture_ctrl.sv
`timescale 1ns/1ps

module capture_ctrl (
    input  logic                   clk50m,
    input  logic                   rst_i,
    input  adc_cap_pkg::cfg_t      cfg_i,
    input  logic                   restart_i,
    input  adc_cap_pkg::sample_t   sample_i,
    input  logic                   sample_valid_i,
    input  logic                   buf_full_i,
    output logic                   sample_en_o,
    output logic                   busy_o,
    output logic                   overflow_o,
    output logic                   wr_en_o,
    output adc_cap_pkg::tx_word_t  wr_data_o
);
    import adc_cap_pkg::*;

    typedef enum logic {IDLE, RUN} state_t;

    state_t               state;
    logic [31:0]          target;
    logic [31:0]          taken_cnt;  // written or dropped
    logic [PKT_CNT_W-1:0] pkt_cnt;
    logic                 wr_req;     // word waiting for the buffer this cycle
    logic                 take;
    logic                 final_word;
    logic                 pkt_end;

    // dual channel needs two words per sample pair
    assign target     = (cfg_i.chsel == 2'b11) ? {cfg_i.num[30:0], 1'b0} : cfg_i.num;
    assign take       = (state == RUN) && sample_valid_i && !restart_i
                        && (cfg_i.stream || taken_cnt < target);
    assign final_word = !cfg_i.stream && (taken_cnt == target - 32'd1);
    assign pkt_end    = (pkt_cnt == PKT_CNT_W'(PKT_WORDS - 1));

    assign busy_o      = (state == RUN);
    assign sample_en_o = (state == RUN);
    assign wr_en_o     = wr_req && !buf_full_i;  // full buffer drops the word

    always_ff @(posedge clk50m) begin
        if (rst_i) begin
            state      <= IDLE;
            taken_cnt  <= '0;
            pkt_cnt    <= '0;
            wr_req     <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            wr_req <= take;
            if (restart_i) begin
                state      <= RUN;
                taken_cnt  <= '0;
                pkt_cnt    <= '0;
                overflow_o <= 1'b0;
            end else begin
                if (wr_req && buf_full_i) overflow_o <= 1'b1;  // sticky
                if (take) begin
                    taken_cnt <= taken_cnt + 32'd1;
                    pkt_cnt   <= pkt_end ? '0 : pkt_cnt + 1'b1;
                end
                // last word goes into the buffer on this same edge
                if (state == RUN && !cfg_i.stream && taken_cnt >= target) state <= IDLE;
            end
        end
    end

    always_ff @(posedge clk50m) begin
        if (take) begin
            wr_data_o.data <= sample_i;
            wr_data_o.last <= pkt_end || final_word;
        end
    end

endmodule

//--- src/cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs (
    input  logic               clk50m,
    input  logic               rst_i,
    input  adc_cap_pkg::cmd_t  cmd_i,
    input  logic               cmd_valid_i,
    output adc_cap_pkg::cfg_t  cfg_o,
    output logic               restart_o
);
    import adc_cap_pkg::*;

    logic restart_hit;

    assign restart_hit = cmd_valid_i && (cmd_i.addr == ADDR_RESTART);  // data ignored

    always_ff @(posedge clk50m) begin
        if (rst_i) begin
            cfg_o.chsel  <= DEF_CHSEL;
            cfg_o.num    <= DEF_NUM;
            cfg_o.div    <= DEF_DIV;
            cfg_o.stream <= 1'b0;
            restart_o    <= 1'b0;
        end else begin
            restart_o <= restart_hit;
            if (cmd_valid_i) begin
                case (cmd_i.addr)
                    ADDR_CHSEL:  cfg_o.chsel  <= cmd_i.data[1:0];
                    ADDR_NUM:    cfg_o.num    <= cmd_i.data;
                    ADDR_DIV:    cfg_o.div    <= cmd_i.data[15:0];
                    ADDR_STREAM: cfg_o.stream <= cmd_i.data[0];
                    default:     cfg_o        <= cfg_o;  // unknown address
                endcase
            end
        end
    end

endmodule

//--- src/cmd_parser.sv
`timescale 1ns/1ps

module cmd_parser (
    input  logic                clk50m,
    input  logic                rst_i,
    input  logic [7:0]          cmd_byte_i,
    input  logic                cmd_byte_valid_i,
    output adc_cap_pkg::cmd_t   cmd_o,
    output logic                cmd_valid_o
);
    import adc_cap_pkg::*;

    typedef enum logic [1:0] {S_HDR0, S_HDR1, S_BODY, S_TRAIL} state_t;

    state_t      state;
    logic [2:0]  body_cnt;
    logic [39:0] body_sr;   // addr then data, msb first
    logic        frame_ok;  // trailer matched on the previous edge

    always_ff @(posedge clk50m) begin
        if (rst_i) begin
            state       <= S_HDR0;
            body_cnt    <= '0;
            frame_ok    <= 1'b0;
            cmd_valid_o <= 1'b0;
        end else begin
            frame_ok    <= 1'b0;
            cmd_valid_o <= frame_ok;
            if (cmd_byte_valid_i) begin
                case (state)
                    S_HDR0: if (cmd_byte_i == CMD_HDR0) state <= S_HDR1;
                    S_HDR1: begin
                        body_cnt <= '0;
                        state    <= (cmd_byte_i == CMD_HDR1) ? S_BODY : S_HDR0;
                    end
                    S_BODY: begin
                        body_cnt <= body_cnt + 3'd1;
                        if (body_cnt == 3'(CMD_BODY_LEN - 1)) state <= S_TRAIL;
                    end
                    S_TRAIL: begin
                        frame_ok <= (cmd_byte_i == CMD_TRAILER);  // bad trailer drops frame
                        state    <= S_HDR0;
                    end
                    default: state <= S_HDR0;
                endcase
            end
        end
    end

    always_ff @(posedge clk50m) begin
        if (cmd_byte_valid_i && state == S_BODY) body_sr <= {body_sr[31:0], cmd_byte_i};
        if (frame_ok) cmd_o <= body_sr;
    end

endmodule

//--- src/pkt_sender.sv
`timescale 1ns/1ps

module pkt_sender (
    input  logic                   clk50m,
    input  logic                   rst_i,
    input  logic                   buf_empty_i,
    input  adc_cap_pkg::tx_word_t  buf_data_i,
    output logic                   buf_rd_o,
    input  logic                   credit_i,
    output adc_cap_pkg::tx_word_t  tx_o,
    output logic                   tx_valid_o
);
    import adc_cap_pkg::*;

    logic [CRED_W-1:0] credits;
    logic [1:0]        inflight;  // reads issued whose word is not yet paid for
    logic              rd_q;      // buffer data valid this cycle

    // only read what the remaining credits can cover
    assign buf_rd_o = !buf_empty_i && (credits > CRED_W'(inflight));

    always_ff @(posedge clk50m) begin
        if (rst_i) begin
            credits    <= CRED_W'(TX_CREDITS);
            inflight   <= '0;
            rd_q       <= 1'b0;
            tx_valid_o <= 1'b0;
        end else begin
            rd_q       <= buf_rd_o;
            tx_valid_o <= rd_q;
            credits    <= credits + CRED_W'(credit_i) - CRED_W'(tx_valid_o);
            inflight   <= inflight + 2'(buf_rd_o) - 2'(tx_valid_o);
        end
    end

    always_ff @(posedge clk50m) begin
        if (rd_q) tx_o <= buf_data_i;  // last flag rides along
    end

endmodule

//--- src/sample_buffer.sv
`timescale 1ns/1ps

module sample_buffer #(
    parameter int DEPTH = adc_cap_pkg::BUF_DEPTH  // power of two
) (
    input  logic                   clk50m,
    input  logic                   rst_i,
    input  logic                   wr_en_i,
    input  adc_cap_pkg::tx_word_t  wr_data_i,
    input  logic                   rd_en_i,
    output adc_cap_pkg::tx_word_t  rd_data_o,
    output logic                   full_o,
    output logic                   empty_o
);
    import adc_cap_pkg::*;

    tx_word_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH):0]     count;
    logic                       do_wr;
    logic                       do_rd;

    assign full_o  = (count == ($clog2(DEPTH) + 1)'(DEPTH));
    assign empty_o = (count == '0);
    assign do_wr   = wr_en_i && !full_o;
    assign do_rd   = rd_en_i && !empty_o;

    always_ff @(posedge clk50m) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // frame store array with registered read port
    always_ff @(posedge clk50m) begin
        if (do_wr) mem[wr_ptr] <= wr_data_i;
        if (do_rd) rd_data_o <= mem[rd_ptr];
    end

endmodule

//--- src/sample_front.sv
`timescale 1ns/1ps

module sample_front (
    input  logic                  clk50m,
    input  logic                  rst_i,
    input  adc_cap_pkg::cfg_t     cfg_i,
    input  logic                  sample_en_i,
    input  logic [11:0]           adc_data_i,
    output logic                  adc_mux_o,
    output adc_cap_pkg::sample_t  sample_o,
    output logic                  sample_valid_o
);
    import adc_cap_pkg::*;

    logic [15:0] div_cnt;
    logic        tick;
    logic        dual;

    assign dual = (cfg_i.chsel == 2'b11);
    assign tick = sample_en_i && (div_cnt == '0);

    always_ff @(posedge clk50m) begin
        if (rst_i) begin
            div_cnt        <= '0;
            adc_mux_o      <= 1'b0;
            sample_valid_o <= 1'b0;
        end else if (!sample_en_i) begin
            // hold divider and mux at their start values
            div_cnt        <= cfg_i.div;
            adc_mux_o      <= (cfg_i.chsel == 2'b10);
            sample_valid_o <= 1'b0;
        end else begin
            sample_valid_o <= tick;
            if (tick) begin
                div_cnt <= cfg_i.div;
                if (dual) adc_mux_o <= ~adc_mux_o;  // alternate A/B
            end else begin
                div_cnt <= div_cnt - 16'd1;
            end
        end
    end

    // tag the value with the channel the mux points at right now
    always_ff @(posedge clk50m) begin
        if (tick) begin
            sample_o.chan  <= adc_mux_o;
            sample_o.pad   <= 3'b000;
            sample_o.value <= adc_data_i;
        end
    end

endmodule
